// ==== src/csr_consts.svh ====
// Machine-mode CSR addresses, field bit positions and fixed ID values.
// RV32 only; hpm counters 3 to 31 and mcounteren have no address here.
`ifndef CSR_CONSTS_SVH
`define CSR_CONSTS_SVH

`define CSR_MSTATUS       12'h300
`define CSR_MISA          12'h301
`define CSR_MIE           12'h304
`define CSR_MTVEC         12'h305
`define CSR_MSTATUSH      12'h310
`define CSR_MCOUNTINHIBIT 12'h320
`define CSR_MSCRATCH      12'h340
`define CSR_MEPC          12'h341
`define CSR_MCAUSE        12'h342
`define CSR_MIP           12'h344
`define CSR_MCYCLE        12'hB00
`define CSR_MINSTRET      12'hB02
`define CSR_MCYCLEH       12'hB80
`define CSR_MINSTRETH     12'hB82
`define CSR_MVENDORID     12'hF11
`define CSR_MARCHID       12'hF12
`define CSR_MIMPID        12'hF13
`define CSR_MHARTID       12'hF14

// Field positions inside mstatus and mcause
`define CSR_MSTATUS_MIE_BIT  3
`define CSR_MSTATUS_MPIE_BIT 7
`define CSR_MSTATUS_MPP_HIGH 12
`define CSR_MSTATUS_MPP_LOW  11
`define CSR_MSTATUS_MPRV_BIT 17
`define CSR_MCAUSE_IRQ_BIT   31
`define CSR_MCAUSE_CODE_HIGH 4
`define CSR_MCAUSE_CODE_LOW  0

// RV32I with MXL = 1
`define CSR_MISA_VALUE   32'h4000_0100
`define CSR_MIMPID_VALUE 32'd1

`endif

// ==== src/csr_pkg.sv ====
// Types shared by the CSR unit. Widths are fixed by the RV32 ISA.
package csr_pkg;

    // Address and data of one CSR access
    typedef logic [11:0] csr_addr_t;
    typedef logic [31:0] csr_data_t;

    // Privilege levels, encoding as in the privileged spec
    typedef enum logic [1:0]
    {
        PRIV_LVL_U = 2'b00,
        PRIV_LVL_S = 2'b01,
        PRIV_LVL_M = 2'b11
    } priv_lvl_e;

    // Read-modify-write flavour of CSRRW/S/C and the immediate forms
    typedef enum logic [1:0]
    {
        CSR_OP_WRITE,
        CSR_OP_SET,
        CSR_OP_CLEAR
    } csr_op_e;

    // Only the mstatus fields that M-mode needs
    typedef struct packed
    {
        logic      mie;
        logic      mpie;
        priv_lvl_e mpp;
        logic      mprv;
    } mstatus_t;

    typedef logic [31:0] mtvec_t;

    typedef struct packed
    {
        logic       irq;
        logic [4:0] trap_code;
    } mcause_t;

endpackage

// ==== src/csr_access_if.sv ====
// Joins decode, register file and writeback for one CSR access.
// Read and write of one cycle share the same address.
interface csr_access_if
    import csr_pkg::*;
();

    // Driven by the decoder
    logic      valid;
    csr_addr_t addr;
    csr_op_e   op;
    csr_data_t operand;
    logic      wr_intent;
    logic      ro_viol;

    // Driven by the register file
    csr_data_t rdata;
    logic      hit;

    // Driven by writeback
    logic      we;
    csr_data_t wdata;

    modport decode (output valid, addr, op, operand, wr_intent, ro_viol);
    modport regs   (input addr, we, wdata, output rdata, hit);
    modport wb     (input valid, op, operand, wr_intent, ro_viol, rdata, hit,
                    output we, wdata);

endinterface

// ==== src/csr.sv ====
// One CSR field; the reset value is set per instance
module csr
#(
    parameter int unsigned          Width      = 32,
    parameter logic [Width-1:0]     ResetValue = '0
)
(
    input  logic             clk_i,
    input  logic             rstn_i,
    input  logic             wr_en_i,
    input  logic [Width-1:0] wr_data_i,
    output logic [Width-1:0] rd_data_o
);

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
            rd_data_o <= ResetValue;
        else if (wr_en_i)
            rd_data_o <= wr_data_i;
    end

    a_wr_data_known: assert property (@(posedge clk_i) disable iff (!rstn_i)
        wr_en_i |-> !$isunknown(wr_data_i));

endmodule

// ==== src/perf_counter.sv ====
// 64-bit event counter. A CSR write wins over the increment of that cycle.
module perf_counter
    import csr_pkg::*;
(
    input  logic        clk_i,
    input  logic        rstn_i,
    input  logic        inc_en_i,
    input  logic        we_i,
    input  logic        weh_i,
    input  csr_data_t   w_value_i,
    output logic [63:0] value_o
);

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
            value_o <= '0;
        else if (we_i)
            value_o[31:0] <= w_value_i;
        else if (weh_i)
            value_o[63:32] <= w_value_i;
        else if (inc_en_i)
            value_o <= value_o + 64'd1;
    end

    // Low and high halves live at different addresses
    a_single_half_write: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !(we_i && weh_i));

endmodule

// ==== src/csr_decoder.sv ====
// Decodes one CSR instruction from its fields. funct3 values with
// bits 1:0 zero are not CSR instructions and are ignored.
module csr_decoder
    import csr_pkg::*;
(
    input  logic            instr_valid_i,
    input  logic [2:0]      funct3_i,
    input  csr_addr_t       csr_addr_i,
    input  csr_data_t       rs1_data_i,
    input  logic            rs1_zero_i,
    csr_access_if.decode    acc
);

    csr_op_e op;

    always_comb
    begin
        case (funct3_i[1:0])
            2'b10:   op = CSR_OP_SET;
            2'b11:   op = CSR_OP_CLEAR;
            default: op = CSR_OP_WRITE;
        endcase
    end

    assign acc.valid = instr_valid_i && (funct3_i[1:0] != 2'b00);
    assign acc.addr  = csr_addr_i;
    assign acc.op    = op;

    // Immediate forms carry a 5-bit zimm in the rs1 field
    assign acc.operand = funct3_i[2] ? {27'd0, rs1_data_i[4:0]} : rs1_data_i;

    // Set or clear with a zero operand is a pure read
    assign acc.wr_intent = (op == CSR_OP_WRITE) || !rs1_zero_i;

    // Addresses 0xC00 and up are read-only
    assign acc.ro_viol = (csr_addr_i[11:10] == 2'b11) && acc.wr_intent;

endmodule

// ==== src/cs_registers.sv ====
// Machine-mode CSR storage, read mux and write decode, plus trap and MRET.
// No interrupt logic; mip is plain storage and mepc is kept word aligned.
`include "csr_consts.svh"

module cs_registers
    import csr_pkg::*;
(
    input  logic        clk_i,
    input  logic        rstn_i,
    csr_access_if.regs  acc,
    input  logic        trap_i,
    input  mcause_t     mcause_i,
    input  csr_data_t   exc_pc_i,
    input  logic        mret_i,
    input  logic        instr_ret_i,
    output csr_data_t   mepc_o,
    output mtvec_t      mtvec_o,
    output priv_lvl_e   priv_lvl_o
);

    localparam mstatus_t MstatusReset = '{mie: 1'b0, mpie: 1'b1, mpp: PRIV_LVL_U, mprv: 1'b0};

    priv_lvl_e priv_d, priv_q;
    mstatus_t  mstatus_d, mstatus_q;
    mcause_t   mcause_d, mcause_q;
    mtvec_t    mtvec_q;
    csr_data_t mepc_d, mepc_q, mcountinhibit_d, mcountinhibit_q;
    csr_data_t mie_q, mip_q, mscratch_q;
    logic      mstatus_wen, mcause_wen, mepc_wen, mtvec_wen;
    logic      mie_wen, mip_wen, mscratch_wen, mcountinhibit_wen;
    logic      mcycle_we, mcycleh_we, minstret_we, minstreth_we;
    logic [63:0] mcycle_q, minstret_q;

    csr #(.Width($bits(mstatus_t)), .ResetValue(MstatusReset)) u_mstatus (
        .clk_i, .rstn_i,
        .wr_en_i(mstatus_wen), .wr_data_i(mstatus_d), .rd_data_o(mstatus_q)
    );
    csr #(.Width(32), .ResetValue('0)) u_mtvec (
        .clk_i, .rstn_i,
        .wr_en_i(mtvec_wen), .wr_data_i(acc.wdata), .rd_data_o(mtvec_q)
    );
    csr #(.Width(32), .ResetValue('0)) u_mie (
        .clk_i, .rstn_i,
        .wr_en_i(mie_wen), .wr_data_i(acc.wdata), .rd_data_o(mie_q)
    );
    csr #(.Width(32), .ResetValue('0)) u_mip (
        .clk_i, .rstn_i,
        .wr_en_i(mip_wen), .wr_data_i(acc.wdata), .rd_data_o(mip_q)
    );
    csr #(.Width(32), .ResetValue('0)) u_mcountinhibit (
        .clk_i, .rstn_i,
        .wr_en_i(mcountinhibit_wen), .wr_data_i(mcountinhibit_d), .rd_data_o(mcountinhibit_q)
    );
    csr #(.Width(32), .ResetValue('0)) u_mscratch (
        .clk_i, .rstn_i,
        .wr_en_i(mscratch_wen), .wr_data_i(acc.wdata), .rd_data_o(mscratch_q)
    );
    csr #(.Width(32), .ResetValue('0)) u_mepc (
        .clk_i, .rstn_i,
        .wr_en_i(mepc_wen), .wr_data_i(mepc_d), .rd_data_o(mepc_q)
    );
    csr #(.Width($bits(mcause_t)), .ResetValue('0)) u_mcause (
        .clk_i, .rstn_i,
        .wr_en_i(mcause_wen), .wr_data_i(mcause_d), .rd_data_o(mcause_q)
    );

    perf_counter u_mcycle (
        .clk_i, .rstn_i, .inc_en_i(!mcountinhibit_q[0]),
        .we_i(mcycle_we), .weh_i(mcycleh_we), .w_value_i(acc.wdata), .value_o(mcycle_q)
    );
    perf_counter u_minstret (
        .clk_i, .rstn_i, .inc_en_i(instr_ret_i && !mcountinhibit_q[2]),
        .we_i(minstret_we), .weh_i(minstreth_we), .w_value_i(acc.wdata), .value_o(minstret_q)
    );

    // Read mux; ID registers are constants
    always_comb
    begin
        acc.rdata = '0;
        acc.hit   = 1'b1;
        case (acc.addr)
            `CSR_MSTATUS:
            begin
                acc.rdata[`CSR_MSTATUS_MIE_BIT]  = mstatus_q.mie;
                acc.rdata[`CSR_MSTATUS_MPIE_BIT] = mstatus_q.mpie;
                acc.rdata[`CSR_MSTATUS_MPP_HIGH:`CSR_MSTATUS_MPP_LOW] = mstatus_q.mpp;
                acc.rdata[`CSR_MSTATUS_MPRV_BIT] = mstatus_q.mprv;
            end
            `CSR_MCAUSE:
            begin
                acc.rdata[`CSR_MCAUSE_IRQ_BIT] = mcause_q.irq;
                acc.rdata[`CSR_MCAUSE_CODE_HIGH:`CSR_MCAUSE_CODE_LOW] = mcause_q.trap_code;
            end
            `CSR_MSTATUSH, `CSR_MVENDORID, `CSR_MARCHID, `CSR_MHARTID: acc.rdata = '0;
            `CSR_MISA:          acc.rdata = `CSR_MISA_VALUE;
            `CSR_MIMPID:        acc.rdata = `CSR_MIMPID_VALUE;
            `CSR_MTVEC:         acc.rdata = mtvec_q;
            `CSR_MIE:           acc.rdata = mie_q;
            `CSR_MIP:           acc.rdata = mip_q;
            `CSR_MCOUNTINHIBIT: acc.rdata = mcountinhibit_q;
            `CSR_MSCRATCH:      acc.rdata = mscratch_q;
            `CSR_MEPC:          acc.rdata = mepc_q;
            `CSR_MCYCLE:        acc.rdata = mcycle_q[31:0];
            `CSR_MCYCLEH:       acc.rdata = mcycle_q[63:32];
            `CSR_MINSTRET:      acc.rdata = minstret_q[31:0];
            `CSR_MINSTRETH:     acc.rdata = minstret_q[63:32];
            default:            acc.hit = 1'b0;
        endcase
    end

    // Only the implemented inhibit bits survive
    assign mcountinhibit_d = {29'd0, acc.wdata[2], 1'b0, acc.wdata[0]};

    // Write decode, then trap or MRET on top
    always_comb
    begin
        priv_d            = priv_q;
        mstatus_wen       = 1'b0;
        mstatus_d         = mstatus_q;
        mcause_wen        = 1'b0;
        mcause_d          = '{irq: acc.wdata[`CSR_MCAUSE_IRQ_BIT],
                              trap_code: acc.wdata[`CSR_MCAUSE_CODE_HIGH:`CSR_MCAUSE_CODE_LOW]};
        mepc_wen          = 1'b0;
        mepc_d            = {acc.wdata[31:2], 2'b00};
        mtvec_wen         = 1'b0;
        mie_wen           = 1'b0;
        mip_wen           = 1'b0;
        mscratch_wen      = 1'b0;
        mcountinhibit_wen = 1'b0;
        mcycle_we         = 1'b0;
        mcycleh_we        = 1'b0;
        minstret_we       = 1'b0;
        minstreth_we      = 1'b0;

        if (acc.we)
        begin
            case (acc.addr)
                `CSR_MSTATUS:
                begin
                    mstatus_wen = 1'b1;
                    mstatus_d   = '{
                        mie:  acc.wdata[`CSR_MSTATUS_MIE_BIT],
                        mpie: acc.wdata[`CSR_MSTATUS_MPIE_BIT],
                        mpp:  priv_lvl_e'(acc.wdata[`CSR_MSTATUS_MPP_HIGH:`CSR_MSTATUS_MPP_LOW]),
                        mprv: acc.wdata[`CSR_MSTATUS_MPRV_BIT]
                    };
                end
                `CSR_MCAUSE:        mcause_wen = 1'b1;
                `CSR_MEPC:          mepc_wen = 1'b1;
                `CSR_MTVEC:         mtvec_wen = 1'b1;
                `CSR_MIE:           mie_wen = 1'b1;
                `CSR_MIP:           mip_wen = 1'b1;
                `CSR_MSCRATCH:      mscratch_wen = 1'b1;
                `CSR_MCOUNTINHIBIT: mcountinhibit_wen = 1'b1;
                `CSR_MCYCLE:        mcycle_we = 1'b1;
                `CSR_MCYCLEH:       mcycleh_we = 1'b1;
                `CSR_MINSTRET:      minstret_we = 1'b1;
                `CSR_MINSTRETH:     minstreth_we = 1'b1;
                default: ;
            endcase
        end

        if (trap_i)
        begin
            // Every trap enters M-mode with interrupts off
            priv_d         = PRIV_LVL_M;
            mstatus_wen    = 1'b1;
            mstatus_d.mpp  = priv_q;
            mstatus_d.mpie = mstatus_q.mie;
            mstatus_d.mie  = 1'b0;
            mcause_wen     = 1'b1;
            mcause_d       = mcause_i;
            mepc_wen       = 1'b1;
            mepc_d         = {exc_pc_i[31:2], 2'b00};
        end
        else if (mret_i)
        begin
            priv_d         = mstatus_q.mpp;
            mstatus_wen    = 1'b1;
            mstatus_d.mie  = mstatus_q.mpie;
            mstatus_d.mpie = 1'b1;
            mstatus_d.mpp  = PRIV_LVL_U;
            // Leaving M-mode drops MPRV
            if (mstatus_q.mpp != PRIV_LVL_M)
                mstatus_d.mprv = 1'b0;
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
            priv_q <= PRIV_LVL_M;
        else
            priv_q <= priv_d;
    end

    assign mepc_o     = mepc_q;
    assign mtvec_o    = mtvec_q;
    assign priv_lvl_o = priv_q;

    a_trap_mret_excl: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !(trap_i && mret_i));

endmodule

// ==== src/csr_writeback.sv ====
// New-value computation and the registered rd result.
// An illegal access returns zero and leaves all CSRs untouched.
module csr_writeback
    import csr_pkg::*;
(
    input  logic        clk_i,
    input  logic        rstn_i,
    csr_access_if.wb    acc,
    output csr_data_t   rd_data_o,
    output logic        rd_valid_o,
    output logic        illegal_o
);

    logic illegal_d;

    always_comb
    begin
        case (acc.op)
            CSR_OP_SET:   acc.wdata = acc.rdata | acc.operand;
            CSR_OP_CLEAR: acc.wdata = acc.rdata & ~acc.operand;
            default:      acc.wdata = acc.operand;
        endcase
    end

    assign acc.we    = acc.valid && acc.wr_intent && acc.hit && !acc.ro_viol;
    assign illegal_d = acc.valid && (!acc.hit || acc.ro_viol);

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            rd_valid_o <= 1'b0;
            illegal_o  <= 1'b0;
        end
        else
        begin
            rd_valid_o <= acc.valid;
            illegal_o  <= illegal_d;
        end
    end

    // Old value of the CSR, sampled before the write lands
    always_ff @(posedge clk_i)
    begin
        if (acc.valid)
            rd_data_o <= illegal_d ? '0 : acc.rdata;
    end

    // A pure read of a read-only CSR is legal
    a_ro_viol_needs_write: assert property (@(posedge clk_i) disable iff (!rstn_i)
        acc.ro_viol |-> acc.wr_intent);

endmodule

// ==== src/csr_unit_top.sv ====
// CSR unit top. One instruction per strobe, no back-pressure; rd, rd_valid
// and illegal follow one cycle after instr_valid_i.
module csr_unit_top
    import csr_pkg::*;
(
    input  logic        clk_i,
    input  logic        rstn_i,

    // CSR instruction fields
    input  logic        instr_valid_i,
    input  logic [2:0]  funct3_i,
    input  csr_addr_t   csr_addr_i,
    input  csr_data_t   rs1_data_i,
    input  logic        rs1_zero_i,

    // Trap, return and retire events
    input  logic        trap_i,
    input  mcause_t     mcause_i,
    input  csr_data_t   exc_pc_i,
    input  logic        mret_i,
    input  logic        instr_ret_i,

    output csr_data_t   rd_data_o,
    output logic        rd_valid_o,
    output logic        illegal_o,
    output csr_data_t   mepc_o,
    output mtvec_t      mtvec_o,
    output priv_lvl_e   priv_lvl_o
);

    csr_access_if acc ();

    csr_decoder u_decoder (
        .instr_valid_i, .funct3_i, .csr_addr_i, .rs1_data_i, .rs1_zero_i,
        .acc(acc.decode)
    );

    cs_registers u_registers (
        .clk_i, .rstn_i, .acc(acc.regs),
        .trap_i, .mcause_i, .exc_pc_i, .mret_i, .instr_ret_i,
        .mepc_o, .mtvec_o, .priv_lvl_o
    );

    csr_writeback u_writeback (
        .clk_i, .rstn_i, .acc(acc.wb),
        .rd_data_o, .rd_valid_o, .illegal_o
    );

endmodule

// ==== testbench/tb_csr_unit.sv ====
// Testbench for the CSR unit. Steps come from testbench/csr_stim.txt,
// so the simulation must start in the project root.
module tb_csr_unit
    import csr_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NumCols    = 13;
    localparam int MaxSteps   = 64;
    localparam int KindInstr  = 1;
    localparam int KindTrap   = 2;
    localparam int KindMret   = 3;
    localparam int KindRetire = 4;

    // Column order of one stimulus line
    typedef enum int
    {
        COL_KIND, COL_F3, COL_ADDR, COL_RS1, COL_RZ, COL_CAUSE, COL_PC,
        COL_RD, COL_ILL, COL_MEPC, COL_MTVEC, COL_PRIV, COL_MASK
    } col_e;

    logic        clk_i = 1'b0;
    logic        rstn_i;
    logic        instr_valid_i;
    logic [2:0]  funct3_i;
    csr_addr_t   csr_addr_i;
    csr_data_t   rs1_data_i;
    logic        rs1_zero_i;
    logic        trap_i;
    mcause_t     mcause_i;
    csr_data_t   exc_pc_i;
    logic        mret_i;
    logic        instr_ret_i;
    csr_data_t   rd_data_o;
    logic        rd_valid_o;
    logic        illegal_o;
    csr_data_t   mepc_o;
    mtvec_t      mtvec_o;
    priv_lvl_e   priv_lvl_o;

    logic [31:0] steps [MaxSteps][NumCols];
    int          n_steps = 0;
    int          errors = 0;
    bit          loaded = 1'b0;

    csr_unit_top dut (.*);

    always #2 clk_i = ~clk_i;

    // Lines starting with # are column notes
    task automatic load_steps();
        int          fd;
        int          code;
        string       line;
        logic [31:0] f [NumCols];
        fd = $fopen("testbench/csr_stim.txt", "r");
        if (fd == 0)
            $display("Could not open testbench/csr_stim.txt");
        else
        begin
            while (!$feof(fd) && n_steps < MaxSteps)
            begin
                code = $fgets(line, fd);
                if (code > 0 && line.len() > 1 && line.getc(0) != "#")
                begin
                    code = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
                                   f[0], f[1], f[2], f[3], f[4], f[5], f[6],
                                   f[7], f[8], f[9], f[10], f[11], f[12]);
                    if (code == NumCols)
                    begin
                        steps[n_steps] = f;
                        n_steps++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic check_outputs(int i);
        logic [31:0] mask;
        logic        is_instr;
        mask = steps[i][COL_MASK];
        is_instr = (steps[i][COL_KIND] == KindInstr);
        assert (rd_valid_o == is_instr) else
        begin
            errors++;
            $display("ERR %0t: step %0d rd_valid %b, expected %b", $time, i, rd_valid_o,
                     is_instr);
        end
        if (is_instr)
        begin
            assert ((rd_data_o & mask) == (steps[i][COL_RD] & mask)) else
            begin
                errors++;
                $display("ERR %0t: step %0d rd %h, expected %h under mask %h", $time, i,
                         rd_data_o, steps[i][COL_RD], mask);
            end
            assert (illegal_o == steps[i][COL_ILL][0]) else
            begin
                errors++;
                $display("ERR %0t: step %0d illegal %b, expected %b", $time, i, illegal_o,
                         steps[i][COL_ILL][0]);
            end
        end
        assert (mepc_o == steps[i][COL_MEPC]) else
        begin
            errors++;
            $display("ERR %0t: step %0d mepc %h, expected %h", $time, i, mepc_o,
                     steps[i][COL_MEPC]);
        end
        assert (mtvec_o == steps[i][COL_MTVEC]) else
        begin
            errors++;
            $display("ERR %0t: step %0d mtvec %h, expected %h", $time, i, mtvec_o,
                     steps[i][COL_MTVEC]);
        end
        assert (priv_lvl_o == steps[i][COL_PRIV][1:0]) else
        begin
            errors++;
            $display("ERR %0t: step %0d priv %0d, expected %0d", $time, i, priv_lvl_o,
                     steps[i][COL_PRIV][1:0]);
        end
    endtask

    // One strobe cycle, then results are sampled mid-cycle after the edge
    task automatic run_step(int i);
        @(posedge clk_i);
        instr_valid_i <= (steps[i][COL_KIND] == KindInstr);
        trap_i        <= (steps[i][COL_KIND] == KindTrap);
        mret_i        <= (steps[i][COL_KIND] == KindMret);
        instr_ret_i   <= (steps[i][COL_KIND] == KindRetire);
        funct3_i      <= steps[i][COL_F3][2:0];
        csr_addr_i    <= steps[i][COL_ADDR][11:0];
        rs1_data_i    <= steps[i][COL_RS1];
        rs1_zero_i    <= steps[i][COL_RZ][0];
        mcause_i      <= mcause_t'(steps[i][COL_CAUSE][5:0]);
        exc_pc_i      <= steps[i][COL_PC];
        @(posedge clk_i);
        instr_valid_i <= 1'b0;
        trap_i        <= 1'b0;
        mret_i        <= 1'b0;
        instr_ret_i   <= 1'b0;
        @(negedge clk_i);
        check_outputs(i);
    endtask

    initial
    begin
        rstn_i        <= 1'b0;
        instr_valid_i <= 1'b0;
        funct3_i      <= '0;
        csr_addr_i    <= '0;
        rs1_data_i    <= '0;
        rs1_zero_i    <= 1'b0;
        trap_i        <= 1'b0;
        mcause_i      <= '0;
        exc_pc_i      <= '0;
        mret_i        <= 1'b0;
        instr_ret_i   <= 1'b0;
        load_steps();
        loaded = 1'b1;
        repeat (3) @(posedge clk_i);
        rstn_i <= 1'b1;
        for (int i = 0; i < n_steps; i++)
            run_step(i);
        if (n_steps == 0)
            $display("No stimulus lines were read");
        $display("Steps run: %0d, errors: %0d", n_steps, errors);
        if (errors == 0 && n_steps > 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

    // Watchdog, sized from the number of stimulus lines
    initial
    begin
        wait (loaded);
        repeat (40 * n_steps + 20) @(posedge clk_i);
        $display("Timeout: the stimulus did not finish in time");
        $display("Verification failed");
        $finish;
    end

endmodule

// ==== testbench/csr_stim.txt ====
# kind(1 instr, 2 trap, 3 mret, 4 retire) funct3 addr rs1 rs1_zero mcause exc_pc
# then expected rd, illegal, mepc, mtvec, priv and the rd compare mask; all hex
1 2 301 00000000 1 00 00000000 40000100 0 00000000 00000000 3 ffffffff
1 2 f13 00000000 1 00 00000000 00000001 0 00000000 00000000 3 ffffffff
1 2 f14 00000000 1 00 00000000 00000000 0 00000000 00000000 3 ffffffff
1 2 300 00000000 1 00 00000000 00000080 0 00000000 00000000 3 ffffffff
1 1 340 a5a50f0f 0 00 00000000 00000000 0 00000000 00000000 3 ffffffff
1 2 340 000000f0 0 00 00000000 a5a50f0f 0 00000000 00000000 3 ffffffff
1 3 340 a0000000 0 00 00000000 a5a50fff 0 00000000 00000000 3 ffffffff
1 7 340 0000000f 0 00 00000000 05a50fff 0 00000000 00000000 3 ffffffff
1 6 340 000003e5 0 00 00000000 05a50ff0 0 00000000 00000000 3 ffffffff
1 2 340 00000000 1 00 00000000 05a50ff5 0 00000000 00000000 3 ffffffff
1 1 341 00001237 0 00 00000000 00000000 0 00001234 00000000 3 ffffffff
1 2 341 00000000 1 00 00000000 00001234 0 00001234 00000000 3 ffffffff
1 1 f11 0000dead 0 00 00000000 00000000 1 00001234 00000000 3 ffffffff
1 2 f11 00000000 1 00 00000000 00000000 0 00001234 00000000 3 ffffffff
1 1 7c0 00001234 0 00 00000000 00000000 1 00001234 00000000 3 ffffffff
1 2 300 00000008 0 00 00000000 00000080 0 00001234 00000000 3 ffffffff
2 0 000 00000000 0 0b 00002000 00000000 0 00002000 00000000 3 ffffffff
1 2 342 00000000 1 00 00000000 0000000b 0 00002000 00000000 3 ffffffff
1 2 300 00000000 1 00 00000000 00001880 0 00002000 00000000 3 ffffffff
1 3 300 00001800 0 00 00000000 00001880 0 00002000 00000000 3 ffffffff
3 0 000 00000000 0 00 00000000 00000000 0 00002000 00000000 0 ffffffff
1 2 300 00000000 1 00 00000000 00000088 0 00002000 00000000 0 ffffffff
1 1 320 00000004 0 00 00000000 00000000 0 00002000 00000000 0 ffffffff
4 0 000 00000000 0 00 00000000 00000000 0 00002000 00000000 0 ffffffff
4 0 000 00000000 0 00 00000000 00000000 0 00002000 00000000 0 ffffffff
1 2 b02 00000000 1 00 00000000 00000000 0 00002000 00000000 0 ffffffff
1 1 320 00000000 1 00 00000000 00000004 0 00002000 00000000 0 ffffffff
4 0 000 00000000 0 00 00000000 00000000 0 00002000 00000000 0 ffffffff
4 0 000 00000000 0 00 00000000 00000000 0 00002000 00000000 0 ffffffff
1 2 b02 00000000 1 00 00000000 00000002 0 00002000 00000000 0 ffffffff
1 1 b80 00000005 0 00 00000000 00000000 0 00002000 00000000 0 ffffffff
1 2 b80 00000000 1 00 00000000 00000005 0 00002000 00000000 0 ffffffff
1 2 b00 00000000 1 00 00000000 00000000 0 00002000 00000000 0 00000000
1 1 305 00000101 0 00 00000000 00000000 0 00002000 00000101 0 ffffffff
1 2 305 00000000 1 00 00000000 00000101 0 00002000 00000101 0 ffffffff

// ==== csr_unit.f ====
+incdir+src
src/csr_pkg.sv
src/csr_access_if.sv
src/csr.sv
src/perf_counter.sv
src/csr_decoder.sv
src/cs_registers.sv
src/csr_writeback.sv
src/csr_unit_top.sv
testbench/tb_csr_unit.sv

// ==== Makefile ====
TOP := tb_csr_unit

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f csr_unit.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f csr_unit.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Verification passed"

clean:
	rm -rf obj_dir
